/* project.f */
logic/pll_ctrl_pkg.sv
logic/pulse_extend.sv
logic/drp_sequencer.sv
logic/lock_monitor.sv
logic/clk_rst_gen.sv
logic/pll_ctrl_sys.sv
dv/pll_drp_model.sv
dv/tb_pll_ctrl.sv

/* Bender.yml */
package:
  name: pll_ctrl

sources:
  - logic/pll_ctrl_pkg.sv
  - logic/pulse_extend.sv
  - logic/drp_sequencer.sv
  - logic/lock_monitor.sv
  - logic/clk_rst_gen.sv
  - logic/pll_ctrl_sys.sv
  - target: test
    files:
      - dv/pll_drp_model.sv
      - dv/tb_pll_ctrl.sv

/* dv/tb_pll_ctrl.sv */
`timescale 1ns/1ps

module tb_pll_ctrl;

  localparam int SEQ_COUNT   = 8;
  localparam int CYCLE_LIMIT = SEQ_COUNT * 200 + 1000;
  localparam logic [31:0] SEED = 32'd63003;

  logic                               CLKS;
  logic                               RSTXS;
  logic [pll_ctrl_pkg::CFG_SEL_W-1:0] cfg_sel;
  logic                               cfg_chg;
  pll_ctrl_pkg::drp_req_t             drp_req;
  pll_ctrl_pkg::drp_rsp_t             drp_rsp;
  logic                               pll_locked;
  logic                               pll_rst;
  logic                               busy;
  logic                               core_rstx;
  logic                               slow_clk;
  logic [2:0]                         rdy_lat;
  logic [4:0]                         lock_dly;
  logic                               force_unlock;

  logic [31:0] rnd_main;
  logic [31:0] rnd_lat;
  logic [15:0] mirror [32];
  int          errors;
  int          cyc;
  int          n_rd;
  int          n_wr;
  int          cyc_lock;
  int          cyc_unlock;
  int          cyc_rise;
  logic        checking;
  logic        outstanding;
  logic        expect_wr;
  logic        loss_pending;
  logic        busy_q;
  logic        locked_q;
  logic        core_q;
  logic [1:0]  cur_sel;

  pll_ctrl_pkg::drp_entry_t exp_entry;

  pll_ctrl_sys i_dut (
    .CLKS       (CLKS),
    .RSTXS      (RSTXS),
    .cfg_sel    (cfg_sel),
    .cfg_chg    (cfg_chg),
    .drp_rsp    (drp_rsp),
    .pll_locked (pll_locked),
    .drp_req    (drp_req),
    .pll_rst    (pll_rst),
    .busy       (busy),
    .core_rstx  (core_rstx),
    .slow_clk   (slow_clk)
  );

  pll_drp_model i_pll (
    .CLKS         (CLKS),
    .RSTXS        (RSTXS),
    .drp_req      (drp_req),
    .pll_rst      (pll_rst),
    .rdy_lat      (rdy_lat),
    .lock_dly     (lock_dly),
    .force_unlock (force_unlock),
    .drp_rsp      (drp_rsp),
    .locked       (pll_locked)
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic draw(output logic [15:0] v);
    rnd_main = lcg_step(rnd_main);
    v = rnd_main[31:16];
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic report_fail(input string what);
    errors++;
    $display("Failure at t=%0t: %s", $time, what);
  endtask

  // Read-modify-write result of one configuration on the mirror.
  task automatic apply_cfg(input logic [1:0] sel);
    pll_ctrl_pkg::drp_entry_t e;
    for (int i = 0; i < pll_ctrl_pkg::CFG_ENTRIES; i++) begin
      e = pll_ctrl_pkg::DRP_CFG_TABLE[sel][i];
      for (int b = 0; b < pll_ctrl_pkg::DRP_DATA_W; b++) begin
        if (e.mask[b]) begin
          mirror[e.addr][b] = e.data[b];
        end
      end
    end
  endtask

  task automatic wait_ready();
    do @(negedge CLKS); while (busy || !core_rstx);
  endtask

  initial begin
    CLKS = 1'b0;
    forever #5 CLKS = ~CLKS;
  end

  always @(posedge CLKS) begin
    cyc <= cyc + 1;
    rnd_lat <= lcg_step(rnd_lat);
    rdy_lat <= 3'(1 + rnd_lat[31:16] % 6);
    if (cyc >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Run ended with %0d errors plus the timeout", errors);
      $display("TEST FAILED");
      $finish;
    end
  end

  always @(negedge CLKS) begin
    if (checking) begin
      check_eq("pll_rst", pll_rst, busy);
      if (drp_req.en) begin
        if (outstanding) begin
          report_fail("DRP strobe issued while a response was outstanding");
        end
        if (!busy) begin
          report_fail("DRP strobe issued outside a sequence");
        end
        check_eq("drp_req.we", drp_req.we, expect_wr);
        if (n_wr < pll_ctrl_pkg::CFG_ENTRIES) begin
          exp_entry = pll_ctrl_pkg::DRP_CFG_TABLE[cur_sel][n_wr];
          check_eq("drp_req.addr", drp_req.addr, exp_entry.addr);
        end
        if (drp_req.we) begin
          check_eq("drp_req.di", drp_req.di, mirror[drp_req.addr]);
          n_wr++;
        end else begin
          n_rd++;
        end
        expect_wr   = ~drp_req.we;
        outstanding = 1'b1;
      end else if (drp_rsp.rdy) begin
        outstanding = 1'b0;
      end
      if (busy_q && !busy) begin
        check_eq("drp_reads", n_rd, pll_ctrl_pkg::CFG_ENTRIES);
        check_eq("drp_writes", n_wr, pll_ctrl_pkg::CFG_ENTRIES);
        for (int a = 0; a < 32; a++) begin
          check_eq($sformatf("pll_reg[%0d]", a), i_pll.regs[a], mirror[a]);
        end
        n_rd = 0;
        n_wr = 0;
      end
      if (pll_locked && !locked_q) begin
        cyc_lock = cyc;
      end
      if (!pll_locked && locked_q) begin
        cyc_unlock   = cyc;
        loss_pending = 1'b1;
      end
      if (core_rstx && !core_q) begin
        cyc_rise = cyc;
        if (cyc - cyc_lock < 31 || cyc - cyc_lock > 35) begin
          report_fail($sformatf("core_rstx rose %0d cycles after lock", cyc - cyc_lock));
        end
      end
      if (loss_pending && !core_rstx) begin
        loss_pending = 1'b0;
      end else if (loss_pending && cyc - cyc_unlock > 4) begin
        report_fail("core_rstx stayed high more than 4 cycles after lock loss");
        loss_pending = 1'b0;
      end
      if (busy && busy_q && core_rstx) begin
        report_fail("core_rstx high while a sequence was running");
      end
      check_eq("slow_clk", slow_clk, core_rstx ? ((cyc - cyc_rise) >> 4) & 1 : 0);
      busy_q   = busy;
      locked_q = pll_locked;
      core_q   = core_rstx;
    end
  end

  initial begin
    logic [15:0] r;
    logic [1:0]  sel;
    rnd_main     = SEED;
    rnd_lat      = SEED;
    errors       = 0;
    cyc          = 0;
    n_rd         = 0;
    n_wr         = 0;
    cyc_lock     = 0;
    cyc_unlock   = 0;
    cyc_rise     = 0;
    checking     = 1'b0;
    outstanding  = 1'b0;
    expect_wr    = 1'b0;
    loss_pending = 1'b0;
    busy_q       = 1'b0;
    locked_q     = 1'b0;
    core_q       = 1'b0;
    cur_sel      = '0;
    RSTXS        = 1'b0;
    cfg_sel      = '0;
    cfg_chg      = 1'b0;
    rdy_lat      = 3'd1;
    force_unlock = 1'b0;
    for (int a = 0; a < 32; a++) begin
      draw(r);
      mirror[a]     = r;
      i_pll.regs[a] = r;
    end
    draw(r);
    lock_dly = 5'(5 + r[3:0]);
    repeat (2) @(posedge CLKS);
    RSTXS    <= 1'b1;
    checking = 1'b1;
    @(negedge CLKS);
    check_eq("drp_req.en", drp_req.en, 0);
    check_eq("drp_req.we", drp_req.we, 0);
    check_eq("pll_rst", pll_rst, 0);
    check_eq("busy", busy, 0);
    check_eq("core_rstx", core_rstx, 0);
    check_eq("slow_clk", slow_clk, 0);
    for (int s = 0; s < SEQ_COUNT; s++) begin
      wait_ready();
      if (s % 3 == 2) begin
        @(posedge CLKS);
        force_unlock <= 1'b1;
        repeat (3) @(posedge CLKS);
        force_unlock <= 1'b0;
        wait_ready();
      end
      draw(r);
      sel = r[15:14];
      @(posedge CLKS);
      cfg_sel  <= sel;
      cfg_chg  <= 1'b1;
      lock_dly <= 5'(5 + r[3:0]);
      cur_sel  = sel;
      apply_cfg(sel);
      @(posedge CLKS);
      cfg_chg <= 1'b0;
      // A second request in the middle of the sequence must be dropped.
      repeat (3 + r[7:5]) @(posedge CLKS);
      cfg_sel <= ~sel;
      cfg_chg <= 1'b1;
      @(posedge CLKS);
      cfg_chg <= 1'b0;
    end
    wait_ready();
    repeat (40) @(negedge CLKS);
    $display("Run finished after %0d cycles with %0d errors", cyc, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* dv/pll_drp_model.sv */
`timescale 1ns/1ps

module pll_drp_model (
  input  logic                   CLKS,
  input  logic                   RSTXS,
  input  pll_ctrl_pkg::drp_req_t drp_req,
  input  logic                   pll_rst,
  input  logic [2:0]             rdy_lat,
  input  logic [4:0]             lock_dly,
  input  logic                   force_unlock,
  output pll_ctrl_pkg::drp_rsp_t drp_rsp,
  output logic                   locked
);

  logic [pll_ctrl_pkg::DRP_DATA_W-1:0] regs [32];
  logic [pll_ctrl_pkg::DRP_ADDR_W-1:0] acc_addr;
  logic [2:0]                          wait_cnt;
  logic                                pending;
  logic [4:0]                          lock_cnt;

  // Writes land at the strobe, the ready pulse follows after the sampled latency.
  always @(posedge CLKS or negedge RSTXS) begin
    if (!RSTXS) begin
      pending  <= 1'b0;
      wait_cnt <= '0;
      acc_addr <= '0;
      drp_rsp  <= '0;
    end else begin
      drp_rsp.rdy <= 1'b0;
      if (drp_req.en) begin
        pending  <= 1'b1;
        wait_cnt <= rdy_lat;
        acc_addr <= drp_req.addr;
        if (drp_req.we) begin
          regs[drp_req.addr] <= drp_req.di;
        end
      end else if (pending) begin
        if (wait_cnt <= 3'd1) begin
          pending      <= 1'b0;
          drp_rsp.rdy  <= 1'b1;
          drp_rsp.dout <= regs[acc_addr];
        end else begin
          wait_cnt <= wait_cnt - 1'b1;
        end
      end
    end
  end

  // The PLL loses lock in reset and relocks lock_dly cycles after release.
  always @(posedge CLKS or negedge RSTXS) begin
    if (!RSTXS) begin
      locked   <= 1'b0;
      lock_cnt <= '0;
    end else if (pll_rst || force_unlock) begin
      locked   <= 1'b0;
      lock_cnt <= '0;
    end else if (!locked) begin
      if (lock_cnt >= lock_dly - 1) begin
        locked <= 1'b1;
      end else begin
        lock_cnt <= lock_cnt + 1'b1;
      end
    end
  end

endmodule

/* logic/pll_ctrl_sys.sv */
`timescale 1ns/1ps

module pll_ctrl_sys (
  input  logic                               CLKS,
  input  logic                               RSTXS,
  input  logic [pll_ctrl_pkg::CFG_SEL_W-1:0] cfg_sel,
  input  logic                               cfg_chg,
  input  pll_ctrl_pkg::drp_rsp_t             drp_rsp,
  input  logic                               pll_locked,
  output pll_ctrl_pkg::drp_req_t             drp_req,
  output logic                               pll_rst,
  output logic                               busy,
  output logic                               core_rstx,
  output logic                               slow_clk
);

  logic lock_stable;

  drp_sequencer u_drp_sequencer (
    .CLKS    (CLKS),
    .RSTXS   (RSTXS),
    .cfg_sel (cfg_sel),
    .cfg_chg (cfg_chg),
    .drp_rsp (drp_rsp),
    .drp_req (drp_req),
    .pll_rst (pll_rst),
    .busy    (busy)
  );

  lock_monitor u_lock_monitor (
    .CLKS        (CLKS),
    .RSTXS       (RSTXS),
    .pll_locked  (pll_locked),
    .lock_stable (lock_stable)
  );

  clk_rst_gen u_clk_rst_gen (
    .CLKS        (CLKS),
    .RSTXS       (RSTXS),
    .lock_stable (lock_stable),
    .busy        (busy),
    .core_rstx   (core_rstx),
    .slow_clk    (slow_clk)
  );

endmodule

/* logic/clk_rst_gen.sv */
`timescale 1ns/1ps

module clk_rst_gen (
  input  logic CLKS,
  input  logic RSTXS,
  input  logic lock_stable,
  input  logic busy,
  output logic core_rstx,
  output logic slow_clk
);

  localparam int STAGES = pll_ctrl_pkg::SLOW_DIV_STAGES;

  logic              release_ok;
  logic              chain_clr;
  logic [STAGES-1:0] stage;
  logic [STAGES-1:0] step;

  assign release_ok = lock_stable & ~busy;

  pulse_extend #(
    .CYCLES (pll_ctrl_pkg::RST_HOLD_CYCLES)
  ) u_rst_hold (
    .CLKS  (CLKS),
    .RSTXS (RSTXS),
    .din   (release_ok),
    .dout  (core_rstx)
  );

  // Clearing on the release condition too lets slow_clk drop together with core_rstx.
  assign chain_clr = ~core_rstx | ~release_ok;

  // Toggle chain; a stage flips when every stage below it is high and about to wrap.
  assign step[0] = 1'b1;

  for (genvar i = 1; i < STAGES; i++) begin : g_step
    assign step[i] = step[i-1] & stage[i-1];
  end

  for (genvar i = 0; i < STAGES; i++) begin : g_div
    always_ff @(posedge CLKS or negedge RSTXS) begin
      if (!RSTXS) begin
        stage[i] <= 1'b0;
      end else if (chain_clr) begin
        stage[i] <= 1'b0;
      end else if (step[i]) begin
        stage[i] <= ~stage[i];
      end
    end
  end

  assign slow_clk = stage[STAGES-1];

endmodule

/* logic/lock_monitor.sv */
`timescale 1ns/1ps

module lock_monitor (
  input  logic CLKS,
  input  logic RSTXS,
  input  logic pll_locked,
  output logic lock_stable
);

  logic [1:0]                            sync_q;
  logic [pll_ctrl_pkg::LOCK_CNT_W-1:0]   run_cnt;

  // Two-flop synchronizer for the asynchronous PLL lock.
  always_ff @(posedge CLKS or negedge RSTXS) begin
    if (!RSTXS) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], pll_locked};
    end
  end

  // Any low sample clears the run, so lock must be seen uninterrupted.
  always_ff @(posedge CLKS or negedge RSTXS) begin
    if (!RSTXS) begin
      run_cnt     <= '0;
      lock_stable <= 1'b0;
    end else if (!sync_q[1]) begin
      run_cnt     <= '0;
      lock_stable <= 1'b0;
    end else if (run_cnt ==
                 pll_ctrl_pkg::LOCK_CNT_W'(pll_ctrl_pkg::LOCK_STABLE_CYCLES - 1)) begin
      lock_stable <= 1'b1;
    end else begin
      run_cnt <= run_cnt + 1'b1;
    end
  end

endmodule

/* logic/drp_sequencer.sv */
`timescale 1ns/1ps

module drp_sequencer (
  input  logic                               CLKS,
  input  logic                               RSTXS,
  input  logic [pll_ctrl_pkg::CFG_SEL_W-1:0] cfg_sel,
  input  logic                               cfg_chg,
  input  pll_ctrl_pkg::drp_rsp_t             drp_rsp,
  output pll_ctrl_pkg::drp_req_t             drp_req,
  output logic                               pll_rst,
  output logic                               busy
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_READ,
    S_READ_WAIT,
    S_WRITE,
    S_WRITE_WAIT
  } state_t;

  state_t                                   state;
  logic [pll_ctrl_pkg::CFG_SEL_W-1:0]       sel_q;
  logic [pll_ctrl_pkg::ENTRY_IDX_W-1:0]     idx;
  logic [pll_ctrl_pkg::DRP_DATA_W-1:0]      wr_data;
  pll_ctrl_pkg::drp_entry_t                 entry;
  logic                                     last_entry;

  assign entry      = pll_ctrl_pkg::DRP_CFG_TABLE[sel_q][idx];
  assign last_entry = (idx == pll_ctrl_pkg::ENTRY_IDX_W'(pll_ctrl_pkg::CFG_ENTRIES - 1));

  // The PLL stays in reset for the whole sequence and is released after the last write.
  always_ff @(posedge CLKS or negedge RSTXS) begin
    if (!RSTXS) begin
      state   <= S_IDLE;
      sel_q   <= '0;
      idx     <= '0;
      busy    <= 1'b0;
      pll_rst <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (cfg_chg) begin
            sel_q   <= cfg_sel;
            idx     <= '0;
            busy    <= 1'b1;
            pll_rst <= 1'b1;
            state   <= S_READ;
          end
        end
        S_READ: begin
          state <= S_READ_WAIT;
        end
        S_READ_WAIT: begin
          if (drp_rsp.rdy) begin
            state <= S_WRITE;
          end
        end
        S_WRITE: begin
          state <= S_WRITE_WAIT;
        end
        S_WRITE_WAIT: begin
          if (drp_rsp.rdy) begin
            if (last_entry) begin
              busy    <= 1'b0;
              pll_rst <= 1'b0;
              state   <= S_IDLE;
            end else begin
              idx   <= idx + 1'b1;
              state <= S_READ;
            end
          end
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  // Merge the read-back value with the table entry.
  always_ff @(posedge CLKS) begin
    if (state == S_READ_WAIT && drp_rsp.rdy) begin
      wr_data <= (drp_rsp.dout & ~entry.mask) | (entry.data & entry.mask);
    end
  end

  assign drp_req.en   = (state == S_READ) || (state == S_WRITE);
  assign drp_req.we   = (state == S_WRITE);
  assign drp_req.addr = entry.addr;
  assign drp_req.di   = wr_data;

endmodule

/* logic/pulse_extend.sv */
`timescale 1ns/1ps

module pulse_extend #(
  parameter int CYCLES = pll_ctrl_pkg::RST_HOLD_CYCLES
) (
  input  logic CLKS,
  input  logic RSTXS,
  input  logic din,
  output logic dout
);

  localparam int CNT_W = (CYCLES > 1) ? $clog2(CYCLES) : 1;

  logic [CNT_W-1:0] cnt;

  // Low passes straight through, high only after din has stayed high long enough.
  always_ff @(posedge CLKS or negedge RSTXS) begin
    if (!RSTXS) begin
      cnt  <= '0;
      dout <= 1'b0;
    end else if (!din) begin
      cnt  <= '0;
      dout <= 1'b0;
    end else if (!dout) begin
      if (cnt == CNT_W'(CYCLES - 1)) begin
        dout <= 1'b1;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

endmodule

/* logic/pll_ctrl_pkg.sv */
package pll_ctrl_pkg;

  localparam int DRP_ADDR_W = 5;
  localparam int DRP_DATA_W = 16;

  localparam int CFG_SEL_W   = 2;
  localparam int CFG_COUNT   = 1 << CFG_SEL_W;
  localparam int CFG_ENTRIES = 4;
  localparam int ENTRY_IDX_W = $clog2(CFG_ENTRIES);

  localparam int LOCK_STABLE_CYCLES = 16;
  localparam int LOCK_CNT_W         = $clog2(LOCK_STABLE_CYCLES);
  localparam int RST_HOLD_CYCLES    = 15;
  localparam int SLOW_DIV_STAGES    = 5;

  // A set mask bit takes the table data bit, a clear one keeps the PLL register bit.
  typedef struct packed {
    logic [DRP_ADDR_W-1:0] addr;
    logic [DRP_DATA_W-1:0] mask;
    logic [DRP_DATA_W-1:0] data;
  } drp_entry_t;

  typedef struct packed {
    logic                  en;
    logic                  we;
    logic [DRP_ADDR_W-1:0] addr;
    logic [DRP_DATA_W-1:0] di;
  } drp_req_t;

  typedef struct packed {
    logic [DRP_DATA_W-1:0] dout;
    logic                  rdy;
  } drp_rsp_t;

  // Output divider, feedback multiplier, lock and filter settings per configuration.
  localparam drp_entry_t DRP_CFG_TABLE [CFG_COUNT][CFG_ENTRIES] = '{
    '{'{5'h08, 16'h0fff, 16'h0041}, '{5'h09, 16'h00ff, 16'h0000},
      '{5'h14, 16'h0fff, 16'h0208}, '{5'h18, 16'h03ff, 16'h00fa}},
    '{'{5'h08, 16'h0fff, 16'h0082}, '{5'h0a, 16'h00ff, 16'h0001},
      '{5'h14, 16'h0fff, 16'h0410}, '{5'h19, 16'h7c00, 16'h3c00}},
    '{'{5'h0b, 16'h0fff, 16'h0104}, '{5'h0c, 16'h00ff, 16'h0080},
      '{5'h15, 16'h0fff, 16'h0186}, '{5'h1a, 16'hffff, 16'h7e9c}},
    '{'{5'h08, 16'hf000, 16'h1000}, '{5'h09, 16'h0fff, 16'h0a5a},
      '{5'h16, 16'h00ff, 16'h0033}, '{5'h1c, 16'h0f0f, 16'h0909}}
  };

endpackage
